// File: hdl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data and address width of the core
`define DATA_W 32

// data RAM size in 32-bit words
// word address wraps modulo this depth
`define RAM_DEPTH_WORDS 256

// cycles from mem_en rising to mem_ready, any value of 1 or more
`define RAM_WAIT_CYCLES 2

`endif

// File: hdl/mem_pkg.sv
package mem_pkg;

    // memory opcode, loads first then stores
    typedef enum logic [3:0] {
        MOP_LB,
        MOP_LBU,
        MOP_LH,
        MOP_LHU,
        MOP_LW,
        MOP_SB,
        MOP_SH,
        MOP_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BEAT0,
        S_BEAT1,
        S_ACK
    } seq_state_e;

    // beats needed for an access, split only when it crosses a word
    function automatic logic [1:0] beat_count(input mem_op_e op, input logic [1:0] byte_off);
        logic [1:0] n;
        n = 2'd1;
        case (op)
            MOP_LH, MOP_LHU, MOP_SH: if (byte_off == 2'd3) n = 2'd2;
            MOP_LW, MOP_SW:          if (byte_off != 2'd0) n = 2'd2;
            default:                 n = 2'd1;
        endcase
        return n;
    endfunction

endpackage

// File: hdl/data_ram.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module data_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_en,
    input  logic                  mem_we,
    input  logic [`DATA_W-1:0]    mem_word_addr,
    input  logic [`DATA_W-1:0]    mem_wmask,
    input  logic [`DATA_W-1:0]    mem_wdata,
    output logic [`DATA_W-1:0]    mem_rdata,
    output logic                  mem_ready
);

    localparam int ADDR_BITS = $clog2(`RAM_DEPTH_WORDS);
    localparam int CNT_W     = $clog2(`RAM_WAIT_CYCLES + 1);

    logic [`DATA_W-1:0]   mem [0:`RAM_DEPTH_WORDS-1];
    logic [CNT_W-1:0]     wait_cnt;
    logic [ADDR_BITS-1:0] word_idx;
    logic                 hit;    // last wait cycle, access happens here

    assign word_idx = mem_word_addr[ADDR_BITS-1:0];    // wraps at depth
    assign hit      = mem_en && !mem_ready &&
                      (wait_cnt == CNT_W'(`RAM_WAIT_CYCLES - 1));

    initial begin
        for (int i = 0; i < `RAM_DEPTH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt  <= '0;
            mem_ready <= 1'b0;
        end else if (mem_ready) begin
            wait_cnt  <= '0;    // one-cycle pulse, restart on next mem_en
            mem_ready <= 1'b0;
        end else if (hit) begin
            wait_cnt  <= '0;
            mem_ready <= 1'b1;
        end else if (mem_en) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always @(posedge clk) begin
        if (hit) begin
            mem_rdata <= mem[word_idx];
            if (mem_we)
                mem[word_idx] <= (mem[word_idx] & ~mem_wmask) | (mem_wdata & mem_wmask);
        end
    end

endmodule

// File: hdl/store_lane_align.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module store_lane_align (
    input  mem_pkg::mem_op_e      op,
    input  logic [1:0]            byte_off,
    input  logic                  beat,
    input  logic [`DATA_W-1:0]    wdata,
    output logic [`DATA_W-1:0]    mem_wmask,
    output logic [`DATA_W-1:0]    mem_wdata
);

    logic [`DATA_W-1:0]   size_mask;
    logic [4:0]           shamt;
    logic [2*`DATA_W-1:0] mask_win;
    logic [2*`DATA_W-1:0] data_win;

    // lanes covered by the access before any shift
    always_comb begin
        case (op)
            mem_pkg::MOP_SB: size_mask = `DATA_W'(8'hff);
            mem_pkg::MOP_SH: size_mask = `DATA_W'(16'hffff);
            mem_pkg::MOP_SW: size_mask = {`DATA_W{1'b1}};
            default:         size_mask = '0;    // loads write nothing
        endcase
    end

    assign shamt = {byte_off, 3'b000};

    // two-word window, low half is the first word and high half the spill
    assign mask_win = {{`DATA_W{1'b0}}, size_mask} << shamt;
    assign data_win = {{`DATA_W{1'b0}}, wdata} << shamt;

    // bytes and aligned words never reach the high half
    always_comb begin
        if (beat) begin
            mem_wmask = mask_win[2*`DATA_W-1:`DATA_W];
            mem_wdata = data_win[2*`DATA_W-1:`DATA_W];
        end else begin
            mem_wmask = mask_win[`DATA_W-1:0];
            mem_wdata = data_win[`DATA_W-1:0];
        end
    end

endmodule

// File: hdl/load_lane_merge.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module load_lane_merge (
    input  mem_pkg::mem_op_e      op,
    input  logic [1:0]            byte_off,
    input  logic [`DATA_W-1:0]    cur_rdata,
    input  logic [`DATA_W-1:0]    prev_rdata,
    output logic [`DATA_W-1:0]    load_value
);

    logic                 split;
    logic [4:0]           shamt;
    logic [2*`DATA_W-1:0] win;
    logic [2*`DATA_W-1:0] win_sh;
    logic [`DATA_W-1:0]   raw;

    assign split = (mem_pkg::beat_count(op, byte_off) == 2'd2);
    assign shamt = {byte_off, 3'b000};

    // split access starts in the previous word, current word sits above it
    assign win    = split ? {cur_rdata, prev_rdata} : {{`DATA_W{1'b0}}, cur_rdata};
    assign win_sh = win >> shamt;
    assign raw    = win_sh[`DATA_W-1:0];

    always_comb begin
        case (op)
            mem_pkg::MOP_LB:  load_value = {{(`DATA_W-8){raw[7]}}, raw[7:0]};
            mem_pkg::MOP_LBU: load_value = {{(`DATA_W-8){1'b0}}, raw[7:0]};
            mem_pkg::MOP_LH:  load_value = {{(`DATA_W-16){raw[15]}}, raw[15:0]};
            mem_pkg::MOP_LHU: load_value = {{(`DATA_W-16){1'b0}}, raw[15:0]};
            mem_pkg::MOP_LW:  load_value = raw;
            default:          load_value = '0;    // stores return nothing
        endcase
    end

endmodule

// File: hdl/mem_access_seq.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module mem_access_seq (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req,
    input  mem_pkg::mem_op_e      op,
    input  logic [`DATA_W-1:0]    addr,
    output logic                  ack,
    output logic [`DATA_W-1:0]    rdata,

    output logic                  beat,
    output logic                  mem_en,
    output logic                  mem_we,
    output logic [`DATA_W-1:0]    mem_word_addr,
    input  logic                  mem_ready,
    input  logic [`DATA_W-1:0]    mem_rdata,

    output logic [`DATA_W-1:0]    prev_rdata,
    input  logic [`DATA_W-1:0]    load_value
);

    mem_pkg::seq_state_e state;
    logic [1:0]          n_beats;    // captured at request time
    logic                is_store;

    assign is_store = (op == mem_pkg::MOP_SB) ||
                      (op == mem_pkg::MOP_SH) ||
                      (op == mem_pkg::MOP_SW);

    assign beat = (state == mem_pkg::S_BEAT1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mem_pkg::S_IDLE;
            ack     <= 1'b0;
            mem_en  <= 1'b0;
            mem_we  <= 1'b0;
            n_beats <= 2'd1;
        end else begin
            case (state)
                mem_pkg::S_IDLE: begin
                    if (req) begin
                        state   <= mem_pkg::S_BEAT0;
                        mem_en  <= 1'b1;
                        mem_we  <= is_store;
                        n_beats <= mem_pkg::beat_count(op, addr[1:0]);
                    end
                end
                mem_pkg::S_BEAT0: begin
                    if (mem_ready) begin
                        mem_en <= 1'b0;    // low for one cycle between beats
                        if (n_beats == 2'd2) begin
                            state <= mem_pkg::S_BEAT1;
                        end else begin
                            state  <= mem_pkg::S_ACK;
                            mem_we <= 1'b0;
                            ack    <= 1'b1;
                        end
                    end
                end
                mem_pkg::S_BEAT1: begin
                    if (!mem_en) begin
                        mem_en <= 1'b1;    // second word request
                    end else if (mem_ready) begin
                        state  <= mem_pkg::S_ACK;
                        mem_en <= 1'b0;
                        mem_we <= 1'b0;
                        ack    <= 1'b1;
                    end
                end
                mem_pkg::S_ACK: begin
                    // hold ack until the requester lets go
                    if (!req) begin
                        state <= mem_pkg::S_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= mem_pkg::S_IDLE;
            endcase
        end
    end

    // word address, previous read word and load result
    always_ff @(posedge clk) begin
        case (state)
            mem_pkg::S_IDLE: begin
                if (req) mem_word_addr <= {2'b00, addr[`DATA_W-1:2]};
            end
            mem_pkg::S_BEAT0: begin
                if (mem_ready) begin
                    prev_rdata <= mem_rdata;
                    if (n_beats == 2'd2)
                        mem_word_addr <= mem_word_addr + `DATA_W'(1);
                    else if (!mem_we)
                        rdata <= load_value;
                end
            end
            mem_pkg::S_BEAT1: begin
                if (mem_en && mem_ready && !mem_we) rdata <= load_value;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/memory_stage_top.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module memory_stage_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  mem_pkg::mem_op_e      op,
    input  logic [`DATA_W-1:0]    addr,
    input  logic [`DATA_W-1:0]    wdata,
    output logic                  ack,
    output logic [`DATA_W-1:0]    rdata
);

    logic                 beat;
    logic                 mem_en;
    logic                 mem_we;
    logic                 mem_ready;
    logic [`DATA_W-1:0]   mem_word_addr;
    logic [`DATA_W-1:0]   mem_wmask;
    logic [`DATA_W-1:0]   mem_wdata;
    logic [`DATA_W-1:0]   mem_rdata;
    logic [`DATA_W-1:0]   prev_rdata;
    logic [`DATA_W-1:0]   load_value;

    mem_access_seq u_seq (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .op            (op),
        .addr          (addr),
        .ack           (ack),
        .rdata         (rdata),
        .beat          (beat),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_word_addr (mem_word_addr),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .prev_rdata    (prev_rdata),
        .load_value    (load_value)
    );

    store_lane_align u_align (
        .op        (op),
        .byte_off  (addr[1:0]),
        .beat      (beat),
        .wdata     (wdata),
        .mem_wmask (mem_wmask),
        .mem_wdata (mem_wdata)
    );

    load_lane_merge u_merge (
        .op         (op),
        .byte_off   (addr[1:0]),
        .cur_rdata  (mem_rdata),
        .prev_rdata (prev_rdata),
        .load_value (load_value)
    );

    data_ram u_ram (
        .clk           (clk),
        .rst           (rst),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_word_addr (mem_word_addr),
        .mem_wmask     (mem_wmask),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .mem_ready     (mem_ready)
    );

endmodule

// File: dv/memory_stage_tests.svh
task automatic reset_and_word_roundtrip;
    @(negedge clk);
    check_val("ack after reset", 32'h0, 32'(ack));
    store_op(mem_pkg::MOP_SW, 32'h0000_0010, 32'hdead_beef);
    load_check(mem_pkg::MOP_LW, 32'h0000_0010);
endtask

task automatic sub_word_sign_rules;
    logic [31:0] got;
    store_op(mem_pkg::MOP_SW, 32'h20, 32'h8f7e_c201);
    store_op(mem_pkg::MOP_SW, 32'h24, 32'h1234_56f0);    // LH at offset 3 reaches here
    for (int off = 0; off < 4; off++) begin
        load_check(mem_pkg::MOP_LB, 32'h20 + off);
        load_check(mem_pkg::MOP_LBU, 32'h20 + off);
        load_check(mem_pkg::MOP_LH, 32'h20 + off);
        load_check(mem_pkg::MOP_LHU, 32'h20 + off);
    end
    do_op(mem_pkg::MOP_LB, 32'h23, '0, got);
    check_val("rdata (LB of 0x8f)", 32'hffff_ff8f, got);
    do_op(mem_pkg::MOP_LHU, 32'h21, '0, got);
    check_val("rdata (LHU of 0x7ec2)", 32'h0000_7ec2, got);
endtask

task automatic misaligned_word_store;
    logic [31:0] base;
    for (int off = 1; off < 4; off++) begin
        base = 32'h40 + 32'(off) * 8;
        store_op(mem_pkg::MOP_SW, base, 32'ha5a5_a5a5);
        store_op(mem_pkg::MOP_SW, base + 4, 32'h5a5a_5a5a);
        store_op(mem_pkg::MOP_SW, base + off, 32'h1122_3344 + off);
        load_check(mem_pkg::MOP_LW, base);    // new bytes up top, low ones kept
        load_check(mem_pkg::MOP_LW, base + 4);
        load_check(mem_pkg::MOP_LW, base + off);
    end
endtask

task automatic split_half_and_byte_stores;
    logic [31:0] got;
    store_op(mem_pkg::MOP_SH, 32'h6b, 32'hffff_9abc);
    load_check(mem_pkg::MOP_LH, 32'h6b);
    load_check(mem_pkg::MOP_LHU, 32'h6b);
    load_check(mem_pkg::MOP_LW, 32'h68);
    load_check(mem_pkg::MOP_LW, 32'h6c);
    do_op(mem_pkg::MOP_LH, 32'h6b, '0, got);
    check_val("rdata (split LH)", 32'hffff_9abc, got);
    store_op(mem_pkg::MOP_SW, 32'h70, 32'h0102_0304);
    for (int off = 0; off < 4; off++) begin
        store_op(mem_pkg::MOP_SB, 32'h70 + off, 32'habcd_ef00 | 32'(off * 16 + 5));
        load_check(mem_pkg::MOP_LW, 32'h70);
        load_check(mem_pkg::MOP_LW, 32'h74);
    end
endtask

// ack and rdata must hold while req stays high
task automatic handshake_hold;
    logic [31:0] first;
    logic        ok;
    store_op(mem_pkg::MOP_SW, 32'h80, 32'h7654_3210);
    @(posedge clk);
    req   <= 1'b1;
    op    <= mem_pkg::MOP_LW;
    addr  <= 32'h80;
    wdata <= '0;
    wait_ack(1'b1, BEAT_LIMIT + 4, ok);
    first = rdata;
    check_val("rdata", 32'h7654_3210, first);
    repeat (6) begin
        @(negedge clk);
        check_val("ack while req held", 32'h1, 32'(ack));
        check_val("rdata while req held", first, rdata);
        check_val("mem_en while req held", 32'h0, 32'(u_dut.mem_en));
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    check_val("ack before req seen low", 32'h1, 32'(ack));
    @(negedge clk);
    check_val("ack after req seen low", 32'h0, 32'(ack));
    repeat (3) begin
        @(negedge clk);
        check_val("mem_en while idle", 32'h0, 32'(u_dut.mem_en));
    end
endtask

task automatic random_mixed_ops;
    mem_pkg::mem_op_e o;
    logic [31:0]      a;
    logic [31:0]      d;
    for (int i = 0; i < 200; i++) begin
        o = mem_pkg::mem_op_e'($urandom_range(7, 0));
        a = $urandom_range(255, 0);    // first 64 words
        d = $urandom;
        if (is_store(o))
            store_op(o, a, d);
        else
            load_check(o, a);
    end
endtask

// File: dv/memory_stage_tb.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module memory_stage_tb;

    localparam int SHADOW_BYTES = `RAM_DEPTH_WORDS * 4;
    localparam int BEAT_LIMIT   = `RAM_WAIT_CYCLES + 4;    // cycles allowed per beat

    logic                 clk;
    logic                 rst;
    logic                 req;
    mem_pkg::mem_op_e     op;
    logic [`DATA_W-1:0]   addr;
    logic [`DATA_W-1:0]   wdata;
    logic                 ack;
    logic [`DATA_W-1:0]   rdata;

    logic [7:0]           shadow [0:SHADOW_BYTES-1];    // byte image of the RAM
    int                   error_count;
    int                   timeout_count;
    int                   check_count;

    memory_stage_top u_dut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata)
    );

    always #4 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
        check_count++;
        if (exp_val !== act_val) begin
            error_count++;
            $display("ERROR at %0t: %s expected 0x%08h, actual 0x%08h",
                     $time, name, exp_val, act_val);
        end
    endtask

    function automatic int op_bytes(input mem_pkg::mem_op_e o);
        case (o)
            mem_pkg::MOP_LB, mem_pkg::MOP_LBU, mem_pkg::MOP_SB: return 1;
            mem_pkg::MOP_LH, mem_pkg::MOP_LHU, mem_pkg::MOP_SH: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic is_store(input mem_pkg::mem_op_e o);
        return (o == mem_pkg::MOP_SB) || (o == mem_pkg::MOP_SH) || (o == mem_pkg::MOP_SW);
    endfunction

    // little endian gather then sign or zero extension
    function automatic logic [31:0] expected_load(input mem_pkg::mem_op_e o,
                                                  input logic [31:0] a);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < op_bytes(o); i++)
            v[8*i +: 8] = shadow[(a + i) % SHADOW_BYTES];
        case (o)
            mem_pkg::MOP_LB: if (v[7]) v[31:8] = '1;
            mem_pkg::MOP_LH: if (v[15]) v[31:16] = '1;
            default: ;
        endcase
        return v;
    endfunction

    task automatic shadow_write(input mem_pkg::mem_op_e o, input logic [31:0] a,
                                input logic [31:0] d);
        for (int i = 0; i < op_bytes(o); i++)
            shadow[(a + i) % SHADOW_BYTES] = d[8*i +: 8];
    endtask

    task automatic wait_ack(input logic level, input int limit, output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < limit) begin
            @(negedge clk);    // sample away from the drive edge
            cycles++;
            ok = (ack === level);
        end
        if (!ok) begin
            timeout_count++;
            $display("Timeout: ack did not go %0s within %0d cycles (op %s, addr 0x%08h)",
                     level ? "high" : "low", limit, op.name(), addr);
        end
    endtask

    task automatic do_op(input mem_pkg::mem_op_e o, input logic [31:0] a,
                         input logic [31:0] d, output logic [31:0] result);
        int   limit;
        logic ok;
        limit = int'(mem_pkg::beat_count(o, a[1:0])) * BEAT_LIMIT + 4;
        @(posedge clk);
        req   <= 1'b1;
        op    <= o;
        addr  <= a;
        wdata <= d;
        wait_ack(1'b1, limit, ok);
        result = rdata;
        @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0, 4, ok);
    endtask

    task automatic store_op(input mem_pkg::mem_op_e o, input logic [31:0] a,
                            input logic [31:0] d);
        logic [31:0] ignored;
        do_op(o, a, d, ignored);
        shadow_write(o, a, d);
    endtask

    task automatic load_check(input mem_pkg::mem_op_e o, input logic [31:0] a);
        logic [31:0] got;
        do_op(o, a, '0, got);
        check_val($sformatf("rdata (%s at 0x%0h)", o.name(), a), expected_load(o, a), got);
    endtask

    `include "memory_stage_tests.svh"

    initial begin
        void'($urandom(32'h18b8_22e6));
        clk           = 1'b0;
        rst           = 1'b1;
        req           = 1'b0;
        op            = mem_pkg::MOP_LW;
        addr          = '0;
        wdata         = '0;
        error_count   = 0;
        timeout_count = 0;
        check_count   = 0;
        for (int i = 0; i < SHADOW_BYTES; i++)
            shadow[i] = 8'h00;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        reset_and_word_roundtrip();
        sub_word_sign_rules();
        misaligned_word_store();
        split_half_and_byte_stores();
        handshake_hold();
        random_mixed_ops();

        $display("checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hdl
+incdir+dv
hdl/mem_pkg.sv
hdl/data_ram.sv
hdl/store_lane_align.sv
hdl/load_lane_merge.sv
hdl/mem_access_seq.sv
hdl/memory_stage_top.sv
dv/memory_stage_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = memory_stage_tb
FILELIST = compile.f
BUILD    = obj_dir
PASS_MSG = Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
